//--- Bender.yml
package:
  name: read_stage

sources:
  - vreg_pkg.sv
  - inst_fifo.sv
  - rename_map.sv
  - preg_file.sv
  - operand_read.sv
  - read_stage_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_checker.sv
      - tb_read_stage.sv

//--- inst_fifo.sv
`timescale 1ns/100ps

module inst_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 rs1_order,
    input  vreg_pkg::vreg_addr_t va_rs1,
    input  logic                 rs2_order,
    input  vreg_pkg::vreg_addr_t va_rs2,
    input  logic                 rd_order,
    input  vreg_pkg::vreg_addr_t va_rd,
    input  vreg_pkg::ctx_t       ctx,
    input  logic                 pop,
    output logic                 fifo_valid,
    output logic                 f_rs1_order,
    output vreg_pkg::vreg_addr_t f_va_rs1,
    output logic                 f_rs2_order,
    output vreg_pkg::vreg_addr_t f_va_rs2,
    output logic                 f_rd_order,
    output vreg_pkg::vreg_addr_t f_va_rd,
    output vreg_pkg::ctx_t       f_ctx,
    output logic                 in_credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;
    logic                 push;
    logic                 rs1_order_mem [DEPTH];
    logic                 rs2_order_mem [DEPTH];
    logic                 rd_order_mem  [DEPTH];
    vreg_pkg::vreg_addr_t va_rs1_mem    [DEPTH];
    vreg_pkg::vreg_addr_t va_rs2_mem    [DEPTH];
    vreg_pkg::vreg_addr_t va_rd_mem     [DEPTH];
    vreg_pkg::ctx_t       ctx_mem       [DEPTH];

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push       = in_valid && (count_q != CNT_W'(DEPTH)); // upstream credits keep this true
    assign fifo_valid = (count_q != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            rs1_order_mem[wr_ptr_q] <= rs1_order;
            va_rs1_mem[wr_ptr_q]    <= va_rs1;
            rs2_order_mem[wr_ptr_q] <= rs2_order;
            va_rs2_mem[wr_ptr_q]    <= va_rs2;
            rd_order_mem[wr_ptr_q]  <= rd_order;
            va_rd_mem[wr_ptr_q]     <= va_rd;
            ctx_mem[wr_ptr_q]       <= ctx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q   <= count_q + CNT_W'(push) - CNT_W'(pop);
            in_credit <= pop; // one credit back per entry freed
        end
    end

    assign f_rs1_order = rs1_order_mem[rd_ptr_q];
    assign f_va_rs1    = va_rs1_mem[rd_ptr_q];
    assign f_rs2_order = rs2_order_mem[rd_ptr_q];
    assign f_va_rs2    = va_rs2_mem[rd_ptr_q];
    assign f_rd_order  = rd_order_mem[rd_ptr_q];
    assign f_va_rd     = va_rd_mem[rd_ptr_q];
    assign f_ctx       = ctx_mem[rd_ptr_q];

endmodule

//--- operand_read.sv
`timescale 1ns/100ps

module operand_read #(
    parameter int NUM_CTX     = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fifo_valid,
    input  logic                 f_rs1_order,
    input  logic                 f_rs2_order,
    input  logic                 f_rd_order,
    input  vreg_pkg::ctx_t       f_ctx,
    input  vreg_pkg::preg_addr_t pa_rs1,
    input  vreg_pkg::preg_addr_t pa_rs2,
    input  vreg_pkg::preg_addr_t pa_rd_new,
    input  logic                 free_empty,
    input  vreg_pkg::word_t      rdata1,
    input  vreg_pkg::word_t      rdata2,
    input  logic                 rready1,
    input  logic                 rready2,
    input  logic                 out_credit,
    input  logic                 branch_open,
    input  logic                 branch_close,
    input  vreg_pkg::ctx_t       branch_ctx,
    output logic                 pop,
    output logic                 alloc,
    output vreg_pkg::preg_addr_t ra1,
    output vreg_pkg::preg_addr_t ra2,
    output logic                 clear_valid,
    output vreg_pkg::preg_addr_t clear_addr,
    output logic                 out_valid,
    output logic                 rs1_ready,
    output vreg_pkg::word_t      d_rs1,
    output logic                 rs2_ready,
    output vreg_pkg::word_t      d_rs2,
    output logic                 rd_ready,
    output vreg_pkg::preg_addr_t pa_rd,
    output logic                 branch_hazard
);
    localparam int BR_W = 4;

    vreg_pkg::rd_state_t  state_q;
    vreg_pkg::rd_state_t  state_d;
    vreg_pkg::credit_t    credits_q;
    logic [BR_W-1:0]      br_cnt_q [NUM_CTX];
    logic                 rs1_order_q;
    logic                 rs2_order_q;
    logic                 rd_order_q;
    vreg_pkg::preg_addr_t pa_rd_q;
    logic                 hazard_q;

    // credits are taken at pop, so the count already covers the send in flight
    assign pop = fifo_valid && (credits_q != '0) && (!f_rd_order || !free_empty);

    assign alloc       = pop && f_rd_order;
    assign clear_valid = alloc;
    assign clear_addr  = pa_rd_new;
    assign ra1         = pa_rs1;
    assign ra2         = pa_rs2;

    always_comb begin
        if (pop) begin
            state_d = vreg_pkg::st_send;
        end else if (fifo_valid && f_rd_order && free_empty && (credits_q != '0)) begin
            state_d = vreg_pkg::st_stall_free;
        end else begin
            state_d = vreg_pkg::st_idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= vreg_pkg::st_idle;
            credits_q <= vreg_pkg::credit_t'(OUT_CREDITS);
        end else begin
            state_q   <= state_d;
            credits_q <= credits_q - vreg_pkg::credit_t'(pop)
                         + vreg_pkg::credit_t'(out_credit);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CTX; c++) begin
                br_cnt_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_CTX; c++) begin
                if (vreg_pkg::ctx_t'(c) == branch_ctx) begin
                    br_cnt_q[c] <= br_cnt_q[c] + BR_W'(branch_open) - BR_W'(branch_close);
                end
            end
        end
    end

    // held for the output cycle, lined up with the registered file read
    always_ff @(posedge clk) begin
        if (pop) begin
            rs1_order_q <= f_rs1_order;
            rs2_order_q <= f_rs2_order;
            rd_order_q  <= f_rd_order;
            pa_rd_q     <= f_rd_order ? pa_rd_new : '0;
            hazard_q    <= (br_cnt_q[f_ctx] != '0);
        end
    end

    assign out_valid     = (state_q == vreg_pkg::st_send);
    assign rs1_ready     = !rs1_order_q || rready1; // unused source counts as ready
    assign d_rs1         = rs1_order_q ? rdata1 : '0;
    assign rs2_ready     = !rs2_order_q || rready2;
    assign d_rs2         = rs2_order_q ? rdata2 : '0;
    assign rd_ready      = rd_order_q;
    assign pa_rd         = pa_rd_q;
    assign branch_hazard = hazard_q;

endmodule

//--- preg_file.sv
`timescale 1ns/100ps

module preg_file #(
    parameter int NUM_PREG = 128
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vreg_pkg::preg_addr_t ra1,
    input  vreg_pkg::preg_addr_t ra2,
    input  logic                 clear_valid,
    input  vreg_pkg::preg_addr_t clear_addr,
    input  logic                 order,
    input  vreg_pkg::preg_addr_t pa_rd,
    input  vreg_pkg::word_t      d_rd,
    output vreg_pkg::word_t      rdata1,
    output vreg_pkg::word_t      rdata2,
    output logic                 rready1,
    output logic                 rready2
);
    vreg_pkg::word_t     data_q [NUM_PREG];
    logic [NUM_PREG-1:0] ready_q;
    logic                byp1;
    logic                byp2;

    // all registers come out of reset ready and holding zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PREG; i++) begin
                data_q[i] <= '0;
            end
            ready_q <= '1;
        end else begin
            if (clear_valid) begin
                ready_q[clear_addr] <= 1'b0;
            end
            if (order) begin // writeback comes last so it beats a clear
                data_q[pa_rd]  <= d_rd;
                ready_q[pa_rd] <= 1'b1;
            end
        end
    end

    assign byp1 = order && (pa_rd == ra1);
    assign byp2 = order && (pa_rd == ra2);

    always_ff @(posedge clk) begin
        rdata1  <= byp1 ? d_rd : data_q[ra1];
        rready1 <= byp1 || ready_q[ra1];
        rdata2  <= byp2 ? d_rd : data_q[ra2];
        rready2 <= byp2 || ready_q[ra2];
    end

endmodule

//--- read_stage_top.sv
`timescale 1ns/100ps

module read_stage_top #(
    parameter int NUM_CTX     = vreg_pkg::NUM_CTX,
    parameter int NUM_PREG    = vreg_pkg::NUM_PREG,
    parameter int IN_DEPTH    = vreg_pkg::IN_DEPTH,
    parameter int OUT_CREDITS = vreg_pkg::OUT_CREDITS
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 rs1_order,
    input  vreg_pkg::vreg_addr_t va_rs1,
    input  logic                 rs2_order,
    input  vreg_pkg::vreg_addr_t va_rs2,
    input  logic                 rd_order,
    input  vreg_pkg::vreg_addr_t va_rd,
    input  vreg_pkg::ctx_t       ctx,
    output logic                 in_credit,
    output logic                 out_valid,
    output logic                 rs1_ready,
    output vreg_pkg::word_t      d_rs1,
    output logic                 rs2_ready,
    output vreg_pkg::word_t      d_rs2,
    output logic                 rd_ready,
    output vreg_pkg::preg_addr_t pa_rd,
    output logic                 branch_hazard,
    input  logic                 out_credit,
    input  logic                 order,
    input  vreg_pkg::preg_addr_t pa_rd_w,
    input  vreg_pkg::word_t      d_rd,
    input  logic                 release_valid,
    input  vreg_pkg::preg_addr_t release_preg,
    input  logic                 branch_open,
    input  logic                 branch_close,
    input  vreg_pkg::ctx_t       branch_ctx
);
    logic                 fifo_valid;
    logic                 fifo_pop;
    logic                 f_rs1_order;
    logic                 f_rs2_order;
    logic                 f_rd_order;
    vreg_pkg::vreg_addr_t f_va_rs1;
    vreg_pkg::vreg_addr_t f_va_rs2;
    vreg_pkg::vreg_addr_t f_va_rd;
    vreg_pkg::ctx_t       f_ctx;
    vreg_pkg::preg_addr_t pa_rs1;
    vreg_pkg::preg_addr_t pa_rs2;
    vreg_pkg::preg_addr_t pa_rd_new;
    logic                 free_empty;
    logic                 alloc;
    vreg_pkg::preg_addr_t ra1;
    vreg_pkg::preg_addr_t ra2;
    logic                 clear_valid;
    vreg_pkg::preg_addr_t clear_addr;
    vreg_pkg::word_t      rdata1;
    vreg_pkg::word_t      rdata2;
    logic                 rready1;
    logic                 rready2;

    inst_fifo #(
        .DEPTH (IN_DEPTH)
    ) i_inst_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .rs1_order   (rs1_order),
        .va_rs1      (va_rs1),
        .rs2_order   (rs2_order),
        .va_rs2      (va_rs2),
        .rd_order    (rd_order),
        .va_rd       (va_rd),
        .ctx         (ctx),
        .pop         (fifo_pop),
        .fifo_valid  (fifo_valid),
        .f_rs1_order (f_rs1_order),
        .f_va_rs1    (f_va_rs1),
        .f_rs2_order (f_rs2_order),
        .f_va_rs2    (f_va_rs2),
        .f_rd_order  (f_rd_order),
        .f_va_rd     (f_va_rd),
        .f_ctx       (f_ctx),
        .in_credit   (in_credit)
    );

    // lookups come straight from the buffer head, the pop is decided alongside
    rename_map #(
        .NUM_CTX  (NUM_CTX),
        .NUM_PREG (NUM_PREG)
    ) i_rename_map (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctx           (f_ctx),
        .va_rs1        (f_va_rs1),
        .va_rs2        (f_va_rs2),
        .va_rd         (f_va_rd),
        .alloc         (alloc),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .pa_rs1        (pa_rs1),
        .pa_rs2        (pa_rs2),
        .pa_rd_new     (pa_rd_new),
        .free_empty    (free_empty)
    );

    preg_file #(
        .NUM_PREG (NUM_PREG)
    ) i_preg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .ra1         (ra1),
        .ra2         (ra2),
        .clear_valid (clear_valid),
        .clear_addr  (clear_addr),
        .order       (order),
        .pa_rd       (pa_rd_w),
        .d_rd        (d_rd),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .rready1     (rready1),
        .rready2     (rready2)
    );

    operand_read #(
        .NUM_CTX     (NUM_CTX),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_operand_read (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo_valid    (fifo_valid),
        .f_rs1_order   (f_rs1_order),
        .f_rs2_order   (f_rs2_order),
        .f_rd_order    (f_rd_order),
        .f_ctx         (f_ctx),
        .pa_rs1        (pa_rs1),
        .pa_rs2        (pa_rs2),
        .pa_rd_new     (pa_rd_new),
        .free_empty    (free_empty),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .rready1       (rready1),
        .rready2       (rready2),
        .out_credit    (out_credit),
        .branch_open   (branch_open),
        .branch_close  (branch_close),
        .branch_ctx    (branch_ctx),
        .pop           (fifo_pop),
        .alloc         (alloc),
        .ra1           (ra1),
        .ra2           (ra2),
        .clear_valid   (clear_valid),
        .clear_addr    (clear_addr),
        .out_valid     (out_valid),
        .rs1_ready     (rs1_ready),
        .d_rs1         (d_rs1),
        .rs2_ready     (rs2_ready),
        .d_rs2         (d_rs2),
        .rd_ready      (rd_ready),
        .pa_rd         (pa_rd),
        .branch_hazard (branch_hazard)
    );

endmodule

//--- rename_map.sv
`timescale 1ns/100ps

module rename_map #(
    parameter int NUM_CTX  = 4,
    parameter int NUM_PREG = 128
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vreg_pkg::ctx_t       ctx,
    input  vreg_pkg::vreg_addr_t va_rs1,
    input  vreg_pkg::vreg_addr_t va_rs2,
    input  vreg_pkg::vreg_addr_t va_rd,
    input  logic                 alloc,
    input  logic                 release_valid,
    input  vreg_pkg::preg_addr_t release_preg,
    output vreg_pkg::preg_addr_t pa_rs1,
    output vreg_pkg::preg_addr_t pa_rs2,
    output vreg_pkg::preg_addr_t pa_rd_new,
    output logic                 free_empty
);
    localparam int NUM_VREG = vreg_pkg::NUM_VREG;
    localparam int PTR_W    = $clog2(NUM_PREG);
    localparam int CNT_W    = $clog2(NUM_PREG + 1);

    vreg_pkg::preg_addr_t map_q [NUM_CTX][NUM_VREG];
    vreg_pkg::preg_addr_t free_mem [NUM_PREG];
    logic [PTR_W-1:0]     head_q;
    logic [PTR_W-1:0]     tail_q;
    logic [CNT_W-1:0]     free_cnt_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(NUM_PREG - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // sources see the mapping from before this cycle's rd update
    assign pa_rs1 = map_q[ctx][va_rs1];
    assign pa_rs2 = map_q[ctx][va_rs2];

    assign pa_rd_new  = free_mem[head_q];
    assign free_empty = (free_cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CTX; c++) begin
                for (int v = 0; v < NUM_VREG; v++) begin
                    map_q[c][v] <= vreg_pkg::preg_addr_t'(c * NUM_VREG + v);
                end
            end
        end else if (alloc) begin
            map_q[ctx][va_rd] <= pa_rd_new;
        end
    end

    always_ff @(posedge clk) begin
        if (release_valid) begin
            free_mem[tail_q] <= release_preg;
        end
    end

    // every register is mapped after reset so the list starts empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q     <= '0;
            tail_q     <= '0;
            free_cnt_q <= '0;
        end else begin
            if (alloc) head_q <= next_ptr(head_q);
            if (release_valid) tail_q <= next_ptr(tail_q);
            free_cnt_q <= free_cnt_q + CNT_W'(release_valid) - CNT_W'(alloc);
        end
    end

endmodule

//--- tb.f
vreg_pkg.sv
inst_fifo.sv
rename_map.sv
preg_file.sv
operand_read.sv
read_stage_top.sv
tb_clock.sv
tb_checker.sv
tb_read_stage.sv

//--- tb_checker.sv
`timescale 1ns/100ps

module tb_checker #(
    parameter int NUM_CTX     = vreg_pkg::NUM_CTX,
    parameter int NUM_PREG    = vreg_pkg::NUM_PREG,
    parameter int OUT_CREDITS = vreg_pkg::OUT_CREDITS
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 rs1_order,
    input vreg_pkg::vreg_addr_t va_rs1,
    input logic                 rs2_order,
    input vreg_pkg::vreg_addr_t va_rs2,
    input logic                 rd_order,
    input vreg_pkg::vreg_addr_t va_rd,
    input vreg_pkg::ctx_t       ctx,
    input logic                 out_valid,
    input logic                 rs1_ready,
    input vreg_pkg::word_t      d_rs1,
    input logic                 rs2_ready,
    input vreg_pkg::word_t      d_rs2,
    input logic                 rd_ready,
    input vreg_pkg::preg_addr_t pa_rd,
    input logic                 branch_hazard,
    input logic                 out_credit,
    input logic                 order,
    input vreg_pkg::preg_addr_t pa_rd_w,
    input vreg_pkg::word_t      d_rd,
    input logic                 release_valid,
    input vreg_pkg::preg_addr_t release_preg,
    input logic                 branch_open,
    input logic                 branch_close,
    input vreg_pkg::ctx_t       branch_ctx
);
    localparam int NUM_VREG = vreg_pkg::NUM_VREG;

    vreg_pkg::preg_addr_t map_m [NUM_CTX][NUM_VREG];
    vreg_pkg::word_t      data_m [NUM_PREG];
    logic [NUM_PREG-1:0]  ready_m;
    vreg_pkg::preg_addr_t free_q [$];
    logic [19:0]          inst_q [$]; // rs1 order/addr, rs2 order/addr, rd order/addr, ctx
    int                   br_cnt [NUM_CTX];
    int                   br_prev [NUM_CTX]; // counts as they stood in the pop cycle
    int                   outstanding;
    int                   beat_count  = 0;
    int                   error_count = 0;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %0t: output %0d %s is %0h, expected %0h",
                     $time, beat_count, what, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int c = 0; c < NUM_CTX; c++) begin
            for (int v = 0; v < NUM_VREG; v++) begin
                map_m[c][v] = vreg_pkg::preg_addr_t'(c * NUM_VREG + v);
            end
            br_cnt[c]  = 0;
            br_prev[c] = 0;
        end
        for (int p = 0; p < NUM_PREG; p++) begin
            data_m[p] = '0;
        end
        ready_m = '1;
        free_q.delete();
        inst_q.delete();
        outstanding = 0;
    endtask

    // sources use the map from before this instruction's own rd allocation
    task automatic check_beat();
        logic [19:0]          inst;
        vreg_pkg::ctx_t       c;
        vreg_pkg::preg_addr_t p1;
        vreg_pkg::preg_addr_t p2;
        vreg_pkg::preg_addr_t pd;
        if (inst_q.size() == 0) begin
            error_count++;
            $display("an output appeared at %0t with no instruction waiting", $time);
            return;
        end
        inst = inst_q.pop_front();
        c    = inst[1:0];
        p1   = map_m[c][inst[18:14]];
        p2   = map_m[c][inst[12:8]];
        compare("rs1_ready", rs1_ready, inst[19] ? ready_m[p1] : 1'b1);
        compare("d_rs1", d_rs1, inst[19] ? data_m[p1] : 32'h0);
        compare("rs2_ready", rs2_ready, inst[13] ? ready_m[p2] : 1'b1);
        compare("d_rs2", d_rs2, inst[13] ? data_m[p2] : 32'h0);
        compare("rd_ready", rd_ready, inst[7]);
        compare("branch_hazard", branch_hazard, br_prev[c] != 0);
        if (!inst[7]) begin
            compare("pa_rd", pa_rd, 32'h0);
        end else if (free_q.size() == 0) begin
            error_count++;
            $display("an instruction with rd went out at %0t while no register was free", $time);
        end else begin
            pd = free_q.pop_front();
            compare("pa_rd", pa_rd, pd);
            map_m[c][inst[6:2]] = pd;
            ready_m[pd]         = 1'b0;
        end
        outstanding++;
        if (outstanding > OUT_CREDITS) begin
            error_count++;
            $display("more than %0d outputs were outstanding at %0t", OUT_CREDITS, $time);
        end
        beat_count++;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            if (out_credit) outstanding--;
            if (out_valid) check_beat();
            for (int i = 0; i < NUM_CTX; i++) begin
                br_prev[i] = br_cnt[i];
            end
            if (order) begin
                data_m[pa_rd_w]  = d_rd;
                ready_m[pa_rd_w] = 1'b1;
            end
            if (release_valid) free_q.push_back(release_preg);
            if (in_valid) begin
                inst_q.push_back({rs1_order, va_rs1, rs2_order, va_rs2, rd_order, va_rd, ctx});
            end
            if (branch_open) br_cnt[branch_ctx] = br_cnt[branch_ctx] + 1;
            if (branch_close) br_cnt[branch_ctx] = br_cnt[branch_ctx] - 1;
        end
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released between edges so no flop sees it change on a rising edge
    end

endmodule

//--- tb_read_stage.sv
`timescale 1ns/100ps

module tb_read_stage;
    localparam int IN_DEPTH  = vreg_pkg::IN_DEPTH;
    localparam int TIMEOUT   = 200;
    localparam int OP_INST   = 0;
    localparam int OP_WR     = 1;
    localparam int OP_REL    = 2;
    localparam int OP_BOPEN  = 3;
    localparam int OP_BCLOSE = 4;
    localparam int OP_WAIT   = 5;
    localparam int OP_HOLD   = 6;
    localparam int OP_END    = 7;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 rs1_order;
    vreg_pkg::vreg_addr_t va_rs1;
    logic                 rs2_order;
    vreg_pkg::vreg_addr_t va_rs2;
    logic                 rd_order;
    vreg_pkg::vreg_addr_t va_rd;
    vreg_pkg::ctx_t       ctx;
    logic                 in_credit;
    logic                 out_valid;
    logic                 rs1_ready;
    vreg_pkg::word_t      d_rs1;
    logic                 rs2_ready;
    vreg_pkg::word_t      d_rs2;
    logic                 rd_ready;
    vreg_pkg::preg_addr_t pa_rd;
    logic                 branch_hazard;
    logic                 out_credit = 1'b0;
    logic                 order;
    vreg_pkg::preg_addr_t pa_rd_w;
    vreg_pkg::word_t      d_rd;
    logic                 release_valid;
    vreg_pkg::preg_addr_t release_preg;
    logic                 branch_open;
    logic                 branch_close;
    vreg_pkg::ctx_t       branch_ctx;

    int     t_op [$];
    int     t_a [$];
    int     t_b [$];
    int     t_c [$];
    int     t_d [$];
    string  t_name [$];
    int     ret_q [$];   // cycle at which each held-back credit is due
    int     sent_total    = 0;
    int     credits_back  = 0;
    int     credits_given = 0;
    int     cycle         = 0;
    int     delay;
    integer seed          = 51;
    logic   hold_credits  = 1'b0;
    logic   hold_q        = 1'b0;
    logic   timed_out     = 1'b0;
    int     tb_errors     = 0;
    int     test_num      = 0;
    int     beat_start    = 0;
    int     err_start     = 0;

    tb_clock i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    read_stage_top i_read_stage_top (.*);

    tb_checker i_checker (.*);

    always @(posedge clk) begin
        if (in_credit) credits_back++;
        if (out_credit) credits_given++;
        if (out_valid) begin
            delay = $random(seed) & 3;
            ret_q.push_back(cycle + 1 + delay);
        end
        hold_q = hold_credits;
        cycle++;
    end

    // the issue queue frees its slots one per cycle at most
    always @(negedge clk) begin
        if (!hold_q && ret_q.size() != 0 && ret_q[0] <= cycle) begin
            void'(ret_q.pop_front());
            out_credit = 1'b1;
        end else begin
            out_credit = 1'b0;
        end
    end

    task automatic add(input int op, input int a, input int b, input int c, input int d,
                       input string name);
        t_op.push_back(op);
        t_a.push_back(a);
        t_b.push_back(b);
        t_c.push_back(c);
        t_d.push_back(d);
        t_name.push_back(name);
    endtask

    // inst rows give ctx, rs1, rs2 and rd with -1 for an unused field
    // write rows give preg and data, release rows give preg and branch rows give ctx
    // wait rows give cycles, hold rows give 1 to hold credits and end rows give the output count
    task automatic build_table();
        add(OP_INST,   0,  1,  2, -1, "");
        add(OP_INST,   3, 31,  0, -1, "");
        add(OP_INST,   2, -1,  7, -1, "");
        add(OP_END,    3,  0,  0,  0, "reset_mapping");
        add(OP_WR,    37, 32'h12345678, 0, 0, "");
        add(OP_INST,   1,  5,  6, -1, "");
        add(OP_INST,   0,  5, -1, -1, "");
        add(OP_WAIT,   4,  0,  0,  0, "");
        add(OP_INST,   2,  9, -1, -1, "");
        add(OP_WR,    73, 32'hcafe0001, 0, 0, ""); // lands on the read edge of the line above
        add(OP_END,    3,  0,  0,  0, "writeback_bypass");
        add(OP_REL,   70,  0,  0,  0, "");
        add(OP_REL,   71,  0,  0,  0, "");
        add(OP_INST,   0, -1, -1, 10, "");
        add(OP_INST,   0,  1, -1, 11, "");
        add(OP_INST,   0, 10, 11, -1, "");
        add(OP_WAIT,   3,  0,  0,  0, "");
        add(OP_WR,    70, 32'h000000aa, 0, 0, "");
        add(OP_INST,   0, 10, 11, -1, "");
        add(OP_END,    4,  0,  0,  0, "rename");
        add(OP_INST,   1,  2, -1,  2, "");
        add(OP_INST,   1,  2, -1, -1, "");
        add(OP_WAIT,   6,  0,  0,  0, "");
        add(OP_REL,  120,  0,  0,  0, "");
        add(OP_END,    2,  0,  0,  0, "free_list_stall");
        add(OP_HOLD,   1,  0,  0,  0, "");
        for (int v = 0; v < 6; v++) begin
            add(OP_INST, 2, v + 3, -1, -1, "");
        end
        add(OP_WAIT,   8,  0,  0,  0, "");
        add(OP_HOLD,   0,  0,  0,  0, "");
        add(OP_END,    6,  0,  0,  0, "credit_backpressure");
        add(OP_BOPEN,  1,  0,  0,  0, "");
        add(OP_BOPEN,  1,  0,  0,  0, "");
        add(OP_INST,   1,  3, -1, -1, "");
        add(OP_INST,   2,  3, -1, -1, "");
        add(OP_BCLOSE, 1,  0,  0,  0, "");
        add(OP_INST,   1,  3, -1, -1, "");
        add(OP_BCLOSE, 1,  0,  0,  0, "");
        add(OP_INST,   1,  3, -1, -1, "");
        add(OP_END,    4,  0,  0,  0, "branch_hazard");
    endtask

    task automatic clear_pulses();
        in_valid      = 1'b0;
        order         = 1'b0;
        release_valid = 1'b0;
        branch_open   = 1'b0;
        branch_close  = 1'b0;
    endtask

    task automatic wait_reset();
        int guard;
        guard = 0;
        while (rst_n !== 1'b1 && guard < 20) begin
            @(posedge clk);
            guard++;
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("reset was never released");
        end
        @(negedge clk);
    endtask

    task automatic wait_upstream_credit();
        int guard;
        guard = 0;
        while (IN_DEPTH + credits_back - sent_total <= 0 && guard < TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (IN_DEPTH + credits_back - sent_total <= 0) begin
            timed_out = 1'b1;
            $display("timed out waiting for an upstream credit");
        end
    endtask

    task automatic finish_test(input int i);
        int guard;
        int beats;
        int errs;
        guard = 0;
        while ((i_checker.beat_count != sent_total || credits_given != i_checker.beat_count)
               && guard < TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (guard >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("timed out draining outputs and credits in test %s", t_name[i]);
        end
        beats = i_checker.beat_count - beat_start;
        if (beats != t_a[i]) begin
            tb_errors++;
            $display("MISMATCH %0t: test %s gave %0d outputs, expected %0d",
                     $time, t_name[i], beats, t_a[i]);
        end
        if (credits_back != sent_total) begin // every buffered entry hands back one credit
            tb_errors++;
            $display("MISMATCH %0t: test %s saw %0d upstream credits in total, expected %0d",
                     $time, t_name[i], credits_back, sent_total);
        end
        errs = i_checker.error_count + tb_errors - err_start;
        $display("test %0d %s: %0d outputs, %0d errors", test_num, t_name[i], beats, errs);
        test_num++;
        beat_start = i_checker.beat_count;
        err_start  = i_checker.error_count + tb_errors;
    endtask

    task automatic apply_op(input int i);
        case (t_op[i])
            OP_INST: begin
                wait_upstream_credit();
                in_valid  = !timed_out;
                ctx       = vreg_pkg::ctx_t'(t_a[i]);
                rs1_order = (t_b[i] >= 0);
                va_rs1    = vreg_pkg::vreg_addr_t'(t_b[i]);
                rs2_order = (t_c[i] >= 0);
                va_rs2    = vreg_pkg::vreg_addr_t'(t_c[i]);
                rd_order  = (t_d[i] >= 0);
                va_rd     = vreg_pkg::vreg_addr_t'(t_d[i]);
                if (!timed_out) sent_total++;
            end
            OP_WR: begin
                order   = 1'b1;
                pa_rd_w = vreg_pkg::preg_addr_t'(t_a[i]);
                d_rd    = vreg_pkg::word_t'(t_b[i]);
            end
            OP_REL: begin
                release_valid = 1'b1;
                release_preg  = vreg_pkg::preg_addr_t'(t_a[i]);
            end
            OP_BOPEN: begin
                branch_open = 1'b1;
                branch_ctx  = vreg_pkg::ctx_t'(t_a[i]);
            end
            OP_BCLOSE: begin
                branch_close = 1'b1;
                branch_ctx   = vreg_pkg::ctx_t'(t_a[i]);
            end
            OP_WAIT: repeat (t_a[i]) @(negedge clk);
            OP_HOLD: hold_credits = (t_a[i] != 0);
            default: finish_test(i);
        endcase
        if (t_op[i] <= OP_BCLOSE) begin
            @(negedge clk);
            clear_pulses();
        end
    endtask

    initial begin
        clear_pulses();
        rs1_order    = 1'b0;
        va_rs1       = '0;
        rs2_order    = 1'b0;
        va_rs2       = '0;
        rd_order     = 1'b0;
        va_rd        = '0;
        ctx          = '0;
        pa_rd_w      = '0;
        d_rd         = '0;
        release_preg = '0;
        branch_ctx   = '0;
        build_table();
        wait_reset();
        for (int i = 0; i < t_op.size(); i++) begin
            if (!timed_out) apply_op(i);
        end
        $display("%0d tests, %0d outputs checked, %0d errors",
                 test_num, i_checker.beat_count, i_checker.error_count + tb_errors);
        if (timed_out || i_checker.error_count + tb_errors != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

//--- vreg_pkg.sv
package vreg_pkg;

    // virtual register number, five bits cover the 32 per context
    typedef logic [4:0] vreg_addr_t;

    // physical register number
    typedef logic [6:0] preg_addr_t;

    typedef logic [31:0] word_t;

    // hardware context number
    typedef logic [1:0] ctx_t;

    // credit counter value, wide enough for the downstream queue
    typedef logic [3:0] credit_t;

    typedef enum logic [1:0] {
        st_idle,       // nothing presented, or waiting on downstream credits
        st_stall_free, // instruction wants an rd but the free list is empty
        st_send        // result presented on the output this cycle
    } rd_state_t;

    localparam int NUM_CTX     = 4;
    localparam int NUM_PREG    = 128;
    localparam int IN_DEPTH    = 4;   // input buffer entries and upstream credits
    localparam int OUT_CREDITS = 4;   // issue queue slots held after reset
    localparam int NUM_VREG    = 32;  // virtual registers per context

endpackage
